//--- hw/sm3Pkg.sv
package sm3Pkg;

	////////////////////
	// Types

	typedef logic [31:0] wordT;

	// Word 0 sits in the top 32 bits
	typedef wordT [0:15] blockT;

	// Field a is the top word so the struct maps onto a chaining value
	typedef struct packed {
		wordT a;
		wordT b;
		wordT c;
		wordT d;
		wordT e;
		wordT f;
		wordT g;
		wordT h;
	} stateT;

	typedef logic [5:0] roundIdxT;

	typedef struct packed {
		logic     load;
		logic     advance;
		roundIdxT round;
	} roundStepT;

	////////////////////
	// Constants

	localparam int numRounds = 64;

	// Boundary between the two boolean and constant regimes
	localparam int lowRounds = 16;

	localparam wordT tLow  = 32'h79cc4519;
	localparam wordT tHigh = 32'h7a879d8a;

	////////////////////
	// Helpers

	// Shift by 32 yields zero, so n of 0 returns x unchanged
	function automatic wordT rotl(input wordT x, input logic [4:0] n);
		return (x << n) | (x >> (6'd32 - {1'b0, n}));
	endfunction

	function automatic wordT p0(input wordT x);
		return x ^ rotl(x, 5'd9) ^ rotl(x, 5'd17);
	endfunction

	function automatic wordT p1(input wordT x);
		return x ^ rotl(x, 5'd15) ^ rotl(x, 5'd23);
	endfunction

	// Parity early, majority late
	function automatic wordT ff(
		input wordT     x,
		input wordT     y,
		input wordT     z,
		input roundIdxT round
	);
		if (round < lowRounds) begin
			return x ^ y ^ z;
		end
		return (x & y) | (x & z) | (y & z);
	endfunction

	// Parity early, choose late
	function automatic wordT gg(
		input wordT     x,
		input wordT     y,
		input wordT     z,
		input roundIdxT round
	);
		if (round < lowRounds) begin
			return x ^ y ^ z;
		end
		return (x & y) | (~x & z);
	endfunction

endpackage

//--- hw/sm3RoundCtrl.sv
module sm3RoundCtrl (
	input  logic              clk,
	input  logic              enable,
	input  logic              start,
	output sm3Pkg::roundStepT step,
	output logic              busy,
	output logic              finish,
	output logic              done
);

	logic             advancing;
	logic             accept;
	logic             lastRound;
	sm3Pkg::roundIdxT roundCnt;

	// New block only taken while idle
	assign accept = start & ~busy;

	assign lastRound = roundCnt == sm3Pkg::roundIdxT'(sm3Pkg::numRounds - 1);

	// Rounds are over but the digest is not yet out
	assign finish = busy & ~advancing;

	// Load acts at the accepting edge, rounds at the edges after it
	assign step = '{load: accept, advance: advancing, round: roundCnt};

	always_ff @(posedge clk or posedge enable) begin
		if (enable) begin
			busy      <= 1'b0;
			advancing <= 1'b0;
			roundCnt  <= '0;
			done      <= 1'b0;
		end else begin
			// Lands with the final XOR in chainOut
			done <= finish;
			if (accept) begin
				busy      <= 1'b1;
				advancing <= 1'b1;
				roundCnt  <= '0;
			end else if (advancing) begin
				roundCnt <= roundCnt + 1'b1;
				if (lastRound) begin
					advancing <= 1'b0;
				end
			end else if (finish) begin
				busy <= 1'b0;
			end
		end
	end

	////////////////////
	// Checks

	loadNotAdvance: assert property (@(posedge clk) disable iff (enable)
		!(step.load && step.advance));

	// Done seen 65 cycles after the accepting edge
	loadToDone: assert property (@(posedge clk) disable iff (enable)
		step.load |-> ##(sm3Pkg::numRounds + 2) done);

endmodule

//--- hw/sm3MsgExpand.sv
module sm3MsgExpand (
	input  logic              clk,
	input  logic              enable,
	input  sm3Pkg::roundStepT step,
	input  sm3Pkg::blockT     block,
	output sm3Pkg::wordT      wj,
	output sm3Pkg::wordT      wjPrime
);

	// Holds W[j] to W[j+15] with W[j] in slot 0
	sm3Pkg::blockT window;

	sm3Pkg::wordT mix;
	sm3Pkg::wordT nextWord;

	////////////////////
	// Expansion

	// W[j+16] from slots 0, 3, 7, 10 and 13
	always_comb begin
		mix      = window[0] ^ window[7] ^ sm3Pkg::rotl(window[13], 5'd15);
		nextWord = sm3Pkg::p1(mix) ^ sm3Pkg::rotl(window[3], 5'd7) ^ window[10];
	end

	always_ff @(posedge clk) begin
		if (step.load) begin
			window <= block;
		end else if (step.advance) begin
			window <= {window[1:15], nextWord};
		end
	end

	// W'[j] needs W[j+4], still inside the window
	assign wj      = window[0];
	assign wjPrime = window[0] ^ window[4];

	////////////////////
	// Checks

	// No shift on the load edge and the fresh window is first used by round 0
	loadThenRoundZero: assert property (@(posedge clk) disable iff (enable)
		step.load |-> !step.advance ##1 (step.advance && step.round == '0));

endmodule

//--- hw/sm3RoundState.sv
module sm3RoundState (
	input  logic              clk,
	input  logic              enable,
	input  sm3Pkg::roundStepT step,
	input  logic              finish,
	input  sm3Pkg::stateT     chainIn,
	input  sm3Pkg::wordT      wj,
	input  sm3Pkg::wordT      wjPrime,
	output sm3Pkg::stateT     chainOut
);

	sm3Pkg::stateT st;
	sm3Pkg::stateT savedChain;
	sm3Pkg::stateT nextSt;

	sm3Pkg::wordT tj;
	sm3Pkg::wordT a12;
	sm3Pkg::wordT ss1;
	sm3Pkg::wordT ss2;
	sm3Pkg::wordT tt1;
	sm3Pkg::wordT tt2;

	////////////////////
	// Round logic

	// Constant rotated by j mod 32
	always_comb begin
		if (step.round < sm3Pkg::lowRounds) begin
			tj = sm3Pkg::rotl(sm3Pkg::tLow, step.round[4:0]);
		end else begin
			tj = sm3Pkg::rotl(sm3Pkg::tHigh, step.round[4:0]);
		end
	end

	always_comb begin
		a12 = sm3Pkg::rotl(st.a, 5'd12);
		ss1 = sm3Pkg::rotl(a12 + st.e + tj, 5'd7);
		ss2 = ss1 ^ a12;
		tt1 = sm3Pkg::ff(st.a, st.b, st.c, step.round) + st.d + ss2 + wjPrime;
		tt2 = sm3Pkg::gg(st.e, st.f, st.g, step.round) + st.h + ss1 + wj;
	end

	// Two rotating shift chains, A to D and E to H
	always_comb begin
		nextSt.a = tt1;
		nextSt.b = st.a;
		nextSt.c = sm3Pkg::rotl(st.b, 5'd9);
		nextSt.d = st.c;
		nextSt.e = sm3Pkg::p0(tt2);
		nextSt.f = st.e;
		nextSt.g = sm3Pkg::rotl(st.f, 5'd19);
		nextSt.h = st.g;
	end

	////////////////////
	// Registers

	always_ff @(posedge clk) begin
		if (step.load) begin
			st         <= chainIn;
			savedChain <= chainIn;
		end else if (step.advance) begin
			st <= nextSt;
		end
	end

	// Digest held until the next completion
	always_ff @(posedge clk or posedge enable) begin
		if (enable) begin
			chainOut <= '0;
		end else if (finish) begin
			chainOut <= st ^ savedChain;
		end
	end

	////////////////////
	// Checks

	// Finish only after the last round and never with a new load
	finishAlone: assert property (@(posedge clk) disable iff (enable)
		finish |-> !step.load && !step.advance);

	finishAfterRounds: assert property (@(posedge clk) disable iff (enable)
		finish |-> $past(step.advance) && $past(step.round) == 6'd63);

endmodule

//--- hw/sm3Compress.sv
module sm3Compress (
	input  logic          clk,
	input  logic          enable,
	input  logic          start,
	input  sm3Pkg::stateT chainIn,
	input  sm3Pkg::blockT block,
	output sm3Pkg::stateT chainOut,
	output logic          busy,
	output logic          done
);

	sm3Pkg::roundStepT step;
	logic              finish;
	sm3Pkg::wordT      wj;
	sm3Pkg::wordT      wjPrime;

	// Sequencing
	sm3RoundCtrl u_ctrl (
		.clk    (clk),
		.enable (enable),
		.start  (start),
		.step   (step),
		.busy   (busy),
		.finish (finish),
		.done   (done)
	);

	// Message schedule
	sm3MsgExpand u_expand (
		.clk     (clk),
		.enable  (enable),
		.step    (step),
		.block   (block),
		.wj      (wj),
		.wjPrime (wjPrime)
	);

	// Compression datapath
	sm3RoundState u_round (
		.clk      (clk),
		.enable   (enable),
		.step     (step),
		.finish   (finish),
		.chainIn  (chainIn),
		.wj       (wj),
		.wjPrime  (wjPrime),
		.chainOut (chainOut)
	);

endmodule

//--- bench/sm3RefModel.svh
`ifndef sm3RefModelSvh
`define sm3RefModelSvh

// Stimulus LCG, 32-bit state
localparam logic [31:0] lcgSeed = 32'd90621;

function automatic logic [31:0] lcgStep(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

////////////////////
// Reference compression

// Expand and compress one block, then XOR with the chaining value
function automatic sm3Pkg::stateT sm3Ref(
	input sm3Pkg::stateT iv,
	input sm3Pkg::blockT blk
);
	sm3Pkg::wordT  w [0:67];
	sm3Pkg::wordT  wp [0:63];
	sm3Pkg::stateT s;
	sm3Pkg::wordT  t;
	sm3Pkg::wordT  ss1;
	sm3Pkg::wordT  ss2;
	sm3Pkg::wordT  tt1;
	sm3Pkg::wordT  tt2;
	int            j;

	for (j = 0; j < 16; j++) begin
		w[j] = blk[j];
	end
	for (j = 16; j < 68; j++) begin
		w[j] = sm3Pkg::p1(w[j-16] ^ w[j-9] ^ sm3Pkg::rotl(w[j-3], 5'd15))
			^ sm3Pkg::rotl(w[j-13], 5'd7) ^ w[j-6];
	end
	for (j = 0; j < 64; j++) begin
		wp[j] = w[j] ^ w[j+4];
	end

	s = iv;
	for (j = 0; j < 64; j++) begin
		t   = (j < 16) ? sm3Pkg::tLow : sm3Pkg::tHigh;
		ss1 = sm3Pkg::rotl(sm3Pkg::rotl(s.a, 5'd12) + s.e + sm3Pkg::rotl(t, 5'(j)), 5'd7);
		ss2 = ss1 ^ sm3Pkg::rotl(s.a, 5'd12);
		tt1 = sm3Pkg::ff(s.a, s.b, s.c, 6'(j)) + s.d + ss2 + wp[j];
		tt2 = sm3Pkg::gg(s.e, s.f, s.g, 6'(j)) + s.h + ss1 + w[j];
		s.d = s.c;
		s.c = sm3Pkg::rotl(s.b, 5'd9);
		s.b = s.a;
		s.a = tt1;
		s.h = s.g;
		s.g = sm3Pkg::rotl(s.f, 5'd19);
		s.f = s.e;
		s.e = sm3Pkg::p0(tt2);
	end
	return s ^ iv;
endfunction

`endif

//--- bench/sm3CompressTb.sv
module sm3CompressTb;

	`include "sm3RefModel.svh"

	localparam int doneTimeout = 200;

	logic          clk;
	logic          enable;
	logic          start;
	sm3Pkg::stateT chainIn;
	sm3Pkg::blockT block;
	sm3Pkg::stateT chainOut;
	logic          busy;
	logic          done;

	sm3Pkg::stateT expQ[$];
	sm3Pkg::stateT expected;
	logic [31:0]   lcgState;
	int            errorCount;
	int            donePulses;
	int            testCount;
	int            failCount;

	sm3Compress u_dut (
		.clk      (clk),
		.enable   (enable),
		.start    (start),
		.chainIn  (chainIn),
		.block    (block),
		.chainOut (chainOut),
		.busy     (busy),
		.done     (done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic sm3Pkg::wordT randomWord();
		lcgState = lcgStep(lcgState);
		return lcgState;
	endfunction

	task automatic randomInputs(output sm3Pkg::stateT chain, output sm3Pkg::blockT blk);
		int i;
		for (i = 0; i < 8; i++) begin
			chain[32*i +: 32] = randomWord();
		end
		for (i = 0; i < 16; i++) begin
			blk[i] = randomWord();
		end
	endtask

	////////////////////
	// Compare

	// One expected digest per done pulse
	always @(negedge clk) begin
		if (!enable && done) begin
			donePulses++;
			assert (expQ.size() > 0) else begin
				$display("Done pulse arrived with no block in flight at time %0t", $time);
				errorCount++;
			end
			if (expQ.size() > 0) begin
				expected = expQ.pop_front();
				assert (chainOut == expected) else begin
					$display("ERROR at %0t: digest %h, expected %h", $time, chainOut, expected);
					errorCount++;
				end
			end
		end
	end

	////////////////////
	// Stimulus

	// A second start with other inputs goes in at cycle interruptAt unless it is 0
	task automatic runBlock(
		input  sm3Pkg::stateT chain,
		input  sm3Pkg::blockT blk,
		input  sm3Pkg::stateT expDigest,
		input  int            interruptAt,
		output int            cycles
	);
		sm3Pkg::stateT altChain;
		sm3Pkg::blockT altBlk;
		randomInputs(altChain, altBlk);
		@(negedge clk);
		chainIn = chain;
		block   = blk;
		start   = 1'b1;
		expQ.push_back(expDigest);
		@(negedge clk);
		start  = 1'b0;
		cycles = 0;
		while (!done && cycles < doneTimeout) begin
			@(negedge clk);
			cycles++;
			// Busy until the edge that raises done
			assert (busy == (cycles < 65)) else begin
				$display("ERROR at %0t: busy %b after %0d cycles", $time, busy, cycles);
				errorCount++;
			end
			start = (cycles == interruptAt);
			if (cycles == interruptAt) begin
				chainIn = altChain;
				block   = altBlk;
			end
		end
		if (!done) begin
			$display("Timed out after %0d cycles waiting for done", cycles);
			$display("Test failed");
			$finish;
		end
	endtask

	// Lets the compare process see the done cycle first
	task automatic finishTest(input string name, input int errorsBefore);
		@(posedge clk);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("PASS %s", name);
		end else begin
			failCount++;
			$display("FAIL %s", name);
		end
	endtask

	initial begin : stimulus
		sm3Pkg::stateT iv;
		sm3Pkg::stateT chain;
		sm3Pkg::stateT mid;
		sm3Pkg::blockT blk;
		sm3Pkg::blockT blk2;
		int            cycles;
		int            errorsBefore;
		int            pulsesBefore;
		int            i;

		enable     = 1'b1;
		start      = 1'b0;
		chainIn    = '0;
		block      = '0;
		lcgState   = lcgSeed;
		errorCount = 0;
		donePulses = 0;
		testCount  = 0;
		failCount  = 0;
		iv = 256'h7380166f_4914b2b9_172442d7_da8a0600_a96f30bc_163138aa_e38dee4d_b0fb0e4e;
		repeat (5) @(posedge clk);
		@(negedge clk);
		enable = 1'b0;

		errorsBefore = errorCount;
		assert (!busy && !done && chainOut == '0) else begin
			$display("ERROR at %0t: busy %b done %b chainOut %h after reset",
				$time, busy, done, chainOut);
			errorCount++;
		end
		finishTest("idle after reset", errorsBefore);

		// Padded "abc"
		errorsBefore = errorCount;
		blk     = '0;
		blk[0]  = 32'h61626380;
		blk[15] = 32'h00000018;
		runBlock(iv, blk,
			256'h66c7f0f4_62eeedd9_d1f2d46b_dc10e4e2_4167c487_5cf2f7a2_297da02b_8f4ba8e0,
			0, cycles);
		assert (cycles == 65) else begin
			$display("ERROR at %0t: done after %0d cycles, expected 65", $time, cycles);
			errorCount++;
		end
		finishTest("abc known vector", errorsBefore);

		errorsBefore = errorCount;
		for (i = 0; i < 20; i++) begin
			randomInputs(chain, blk);
			runBlock(chain, blk, sm3Ref(chain, blk), 0, cycles);
		end
		finishTest("random blocks", errorsBefore);

		// "abcd" times 16 with the digest of block 1 fed back
		errorsBefore = errorCount;
		for (i = 0; i < 16; i++) begin
			blk[i] = 32'h61626364;
		end
		blk2     = '0;
		blk2[0]  = 32'h80000000;
		blk2[15] = 32'h00000200;
		runBlock(iv, blk, sm3Ref(iv, blk), 0, cycles);
		mid = chainOut;
		runBlock(mid, blk2, sm3Ref(sm3Ref(iv, blk), blk2), 0, cycles);
		finishTest("two-block chaining", errorsBefore);

		errorsBefore = errorCount;
		pulsesBefore = donePulses;
		randomInputs(chain, blk);
		runBlock(chain, blk, sm3Ref(chain, blk), 20, cycles);
		repeat (80) @(negedge clk);
		assert (donePulses - pulsesBefore == 1) else begin
			$display("ERROR at %0t: %0d done pulses, expected 1",
				$time, donePulses - pulsesBefore);
			errorCount++;
		end
		finishTest("start while busy", errorsBefore);

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			testCount, testCount - failCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- sm3Compress.f
+incdir+bench
hw/sm3Pkg.sv
hw/sm3RoundCtrl.sv
hw/sm3MsgExpand.sv
hw/sm3RoundState.sv
hw/sm3Compress.sv
bench/sm3CompressTb.sv

//--- Bender.yml
package:
  name: sm3Compress

sources:
  - files:
      - hw/sm3Pkg.sv
      - hw/sm3RoundCtrl.sv
      - hw/sm3MsgExpand.sv
      - hw/sm3RoundState.sv
      - hw/sm3Compress.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/sm3CompressTb.sv
